// File: hw/agu_pkg.sv
// Shared widths, enums and bus structs for the load/store address unit, imported by RTL and testbench
`default_nettype none

package agu_pkg;

  // Datapath and bus widths
  localparam int xlen      = 32;
  localparam int addr_size = 32;
  localparam int strb_w    = xlen / 8;

  // Instruction class from decode
  typedef enum logic [1:0] {
    op_load,
    op_store,
    op_amo
  } agu_op_e;

  // Access size, same encoding as the bus size field
  typedef enum logic [1:0] {
    size_b,
    size_h,
    size_w
  } acc_size_e;

  // ALU operation, also used as the AMO opcode
  typedef enum logic [3:0] {
    alu_add,
    alu_swap,
    alu_and,
    alu_or,
    alu_xor,
    alu_max,
    alu_min,
    alu_maxu,
    alu_minu
  } alu_op_e;

  // AMO sequencer states
  typedef enum logic [2:0] {
    st_idle,
    st_first,
    st_amoalu,
    st_amordy,
    st_wait2nd,
    st_second,
    st_wbck
  } icb_state_e;

  //////////////////////////////////////////////////
  // Bundles

  typedef struct packed {
    agu_op_e   op;
    acc_size_e size;
    alu_op_e   amo_op;
    logic      usign;
  } agu_info_t;

  typedef struct packed {
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    alu_op_e         op;
  } alu_req_t;

  // Command payload, valid/ready travel beside it
  typedef struct packed {
    logic [addr_size-1:0] addr;
    logic                 read;
    logic [xlen-1:0]      wdata;
    logic [strb_w-1:0]    wmask;
    logic                 lock;
    acc_size_e            size;
    logic                 usign;
  } icb_cmd_t;

  typedef struct packed {
    logic            err;
    logic [xlen-1:0] rdata;
  } icb_rsp_t;

  // Commit report toward the exception logic
  typedef struct packed {
    logic                 misalgn;
    logic                 ld;
    logic                 stamo;
    logic                 buserr;
    logic [addr_size-1:0] badaddr;
  } cmt_t;

endpackage

`default_nettype wire

// File: hw/agu_alu.sv
// Combinational adder and AMO logic for address generation and the read-modify-write step
`default_nettype none

module agu_alu (
  input  agu_pkg::alu_req_t        req,
  output logic [agu_pkg::xlen-1:0] res
);

  import agu_pkg::*;

  logic [xlen-1:0] sum;
  logic            lt_s;
  logic            lt_u;

  assign sum  = req.op1 + req.op2;

  // Signed and unsigned less-than of op1 versus op2
  assign lt_s = $signed(req.op1) < $signed(req.op2);
  assign lt_u = req.op1 < req.op2;

  always_comb begin
    case (req.op)
      alu_add:  res = sum;
      // Swap stores rs2 unchanged
      alu_swap: res = req.op2;
      alu_and:  res = req.op1 & req.op2;
      alu_or:   res = req.op1 | req.op2;
      alu_xor:  res = req.op1 ^ req.op2;
      alu_max:  res = lt_s ? req.op2 : req.op1;
      alu_min:  res = lt_s ? req.op1 : req.op2;
      alu_maxu: res = lt_u ? req.op2 : req.op1;
      alu_minu: res = lt_u ? req.op1 : req.op2;
      default:  res = sum;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/st_lane_align.sv
// Size decode with misalignment check and store lane replication plus byte mask for the bus
`default_nettype none

module st_lane_align (
  input  agu_pkg::acc_size_e            size,
  input  wire [agu_pkg::addr_size-1:0]  addr,
  input  wire [agu_pkg::xlen-1:0]       rs2,
  output logic                          misalgn,
  output logic [agu_pkg::xlen-1:0]      lane_wdata,
  output logic [agu_pkg::strb_w-1:0]    lane_wmask
);

  import agu_pkg::*;

  // Halfword needs bit 0 clear, word needs both low bits clear
  assign misalgn = ((size == size_h) & addr[0])
                 | ((size == size_w) & (|addr[1:0]));

  always_comb begin
    case (size)
      size_b: begin
        // Byte copied to all four lanes
        lane_wdata = {4{rs2[7:0]}};
        lane_wmask = strb_w'(1) << addr[1:0];
      end
      size_h: begin
        lane_wdata = {2{rs2[15:0]}};
        lane_wmask = strb_w'(3) << {addr[1], 1'b0};
      end
      size_w: begin
        lane_wdata = rs2;
        lane_wmask = '1;
      end
      default: begin
        lane_wdata = rs2;
        lane_wmask = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/amo_sequencer.sv
// AMO read-modify-write sequencer with its data buffers and the ALU operand mux, used inside agu_top
`default_nettype none

module amo_sequencer (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      start,
  input  agu_pkg::agu_info_t       i_info,
  input  wire [agu_pkg::xlen-1:0]  rs1,
  input  wire [agu_pkg::xlen-1:0]  rs2,
  input  wire [agu_pkg::xlen-1:0]  imm,
  input  wire                      icb_cmd_ready,
  input  wire                      icb_rsp_valid,
  input  agu_pkg::icb_rsp_t        icb_rsp,
  input  wire                      o_ready,
  input  wire [agu_pkg::xlen-1:0]  alu_res,
  output agu_pkg::icb_state_e      state,
  output agu_pkg::alu_req_t        alu_req,
  output logic [agu_pkg::xlen-1:0] rd_buf,
  output logic [agu_pkg::xlen-1:0] res_buf,
  output logic                     err_flag
);

  import agu_pkg::*;

  icb_state_e      state_nxt;
  logic            rsp_first;
  logic            rsp_second;
  logic [xlen-1:0] addr_op2;

  //////////////////////////////////////////////////
  // State machine

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:    if (start) state_nxt = st_first;
      // Read data is back
      st_first:   if (icb_rsp_valid) state_nxt = st_amoalu;
      // ALU result is ready one cycle later, no stall possible
      st_amoalu:  state_nxt = st_amordy;
      st_amordy:  state_nxt = st_wait2nd;
      // Write command sits on the bus until taken
      st_wait2nd: if (icb_cmd_ready) state_nxt = st_second;
      st_second:  if (icb_rsp_valid) state_nxt = st_wbck;
      // Retire once commit takes it
      st_wbck:    if (o_ready) state_nxt = st_idle;
      default:    state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  //////////////////////////////////////////////////
  // Read data, result and error buffers

  assign rsp_first  = (state == st_first) & icb_rsp_valid;
  assign rsp_second = (state == st_second) & icb_rsp_valid;

  // Old memory word, later written back to rd
  always_ff @(posedge clk) begin
    if (rsp_first) begin
      rd_buf <= icb_rsp.rdata;
    end
  end

  // Modified word for the write command
  always_ff @(posedge clk) begin
    if (state == st_amoalu) begin
      res_buf <= alu_res;
    end
  end

  // Error from the read, merged with the write error
  always_ff @(posedge clk) begin
    if (rst) begin
      err_flag <= 1'b0;
    end else if (rsp_first) begin
      err_flag <= icb_rsp.err;
    end else if (rsp_second) begin
      err_flag <= err_flag | icb_rsp.err;
    end
  end

  //////////////////////////////////////////////////
  // ALU operand select

  // AMOs address with rs1 alone
  assign addr_op2 = (i_info.op == op_amo) ? '0 : imm;

  always_comb begin
    if (state == st_amoalu) begin
      // Modify step on old word and rs2
      alu_req.op1 = rd_buf;
      alu_req.op2 = rs2;
      alu_req.op  = i_info.amo_op;
    end else begin
      // Address add, also keeps the address steady for the write
      alu_req.op1 = rs1;
      alu_req.op2 = addr_op2;
      alu_req.op  = alu_add;
    end
  end

endmodule

`default_nettype wire

// File: hw/agu_issue.sv
// Handshake strobes, bus command and commit report for loads, stores and AMOs in agu_top
`default_nettype none

module agu_issue (
  input  wire                           i_valid,
  input  agu_pkg::agu_info_t            i_info,
  input  wire                           o_ready,
  input  wire                           icb_cmd_ready,
  input  wire [agu_pkg::addr_size-1:0]  addr,
  input  wire                           misalgn,
  input  wire [agu_pkg::xlen-1:0]       lane_wdata,
  input  wire [agu_pkg::strb_w-1:0]     lane_wmask,
  input  agu_pkg::icb_state_e           state,
  input  wire [agu_pkg::xlen-1:0]       rd_buf,
  input  wire [agu_pkg::xlen-1:0]       res_buf,
  input  wire                           err_flag,
  output logic                          i_ready,
  output logic                          o_valid,
  output logic                          start,
  output logic                          icb_cmd_valid,
  output agu_pkg::icb_cmd_t             icb_cmd,
  output logic [agu_pkg::xlen-1:0]      wbck_wdat,
  output logic                          wbck_err,
  output agu_pkg::cmt_t                 cmt,
  output logic                          amo_wait
);

  import agu_pkg::*;

  logic is_ld;
  logic is_st;
  logic is_amo;
  logic algn_ldst;
  logic unalgn;
  logic algn_amo;
  logic sta_idle;
  logic sta_wait2nd;
  logic sta_wbck;

  //////////////////////////////////////////////////
  // Classify

  assign is_ld     = (i_info.op == op_load);
  assign is_st     = (i_info.op == op_store);
  assign is_amo    = (i_info.op == op_amo);
  assign algn_ldst = ~misalgn & (is_ld | is_st);
  // Alignment is decided in idle because the address carries the AMO result in st_amoalu
  assign algn_amo  = is_amo & (~sta_idle | ~misalgn);
  // Any misaligned access becomes an exception at commit
  assign unalgn    = sta_idle & misalgn & (is_ld | is_st | is_amo);

  assign sta_idle    = (state == st_idle);
  assign sta_wait2nd = (state == st_wait2nd);
  assign sta_wbck    = (state == st_wbck);
  assign amo_wait    = ~sta_idle;

  //////////////////////////////////////////////////
  // Strobes

  // AMO frees issue only at retirement
  assign i_ready = algn_amo ? (sta_wbck & o_ready) : (icb_cmd_ready & o_ready);

  // Same-cycle commit for plain and faulting accesses gated by cmd ready
  assign o_valid = sta_wbck | (i_valid & (algn_ldst | unalgn) & icb_cmd_ready);

  // Commit must be able to take it in the same cycle
  assign icb_cmd_valid = (algn_ldst & i_valid & o_ready)
                       | (algn_amo & ((sta_idle & i_valid & o_ready) | sta_wait2nd));

  // AMO read taken in idle
  assign start = algn_amo & sta_idle & i_valid & o_ready & icb_cmd_ready;

  //////////////////////////////////////////////////
  // Command and commit payloads

  always_comb begin
    icb_cmd.addr  = addr;
    icb_cmd.read  = (algn_ldst & is_ld) | (algn_amo & sta_idle);
    icb_cmd.wdata = is_amo ? res_buf : lane_wdata;
    // Failed AMO read turns the write into a no-op
    icb_cmd.wmask = is_amo ? (err_flag ? '0 : '1) : lane_wmask;
    icb_cmd.lock  = algn_amo & sta_idle;
    icb_cmd.size  = i_info.size;
    icb_cmd.usign = i_info.usign;
  end

  always_comb begin
    cmt.misalgn = unalgn;
    cmt.ld      = is_ld;
    cmt.stamo   = is_st | is_amo;
    cmt.buserr  = algn_amo & err_flag;
    cmt.badaddr = addr;
  end

  assign wbck_wdat = algn_amo ? rd_buf : '0;
  assign wbck_err  = cmt.buserr | cmt.misalgn;

endmodule

`default_nettype wire

// File: hw/agu_top.sv
// Load/store address unit top level; instantiate once per core between issue and the memory bus
`default_nettype none

module agu_top (
  input  wire                      clk,
  input  wire                      rst,
  // Issue handshake
  input  wire                      i_valid,
  output logic                     i_ready,
  input  agu_pkg::agu_info_t       i_info,
  input  wire [agu_pkg::xlen-1:0]  rs1,
  input  wire [agu_pkg::xlen-1:0]  rs2,
  input  wire [agu_pkg::xlen-1:0]  imm,
  // Commit and write-back
  output logic                     o_valid,
  input  wire                      o_ready,
  output logic [agu_pkg::xlen-1:0] wbck_wdat,
  output logic                     wbck_err,
  output agu_pkg::cmt_t            cmt,
  output logic                     amo_wait,
  // Memory command bus
  output logic                     icb_cmd_valid,
  input  wire                      icb_cmd_ready,
  output agu_pkg::icb_cmd_t        icb_cmd,
  input  wire                      icb_rsp_valid,
  input  agu_pkg::icb_rsp_t        icb_rsp
);

  import agu_pkg::*;

  icb_state_e           state;
  alu_req_t             alu_req;
  logic [xlen-1:0]      alu_res;
  logic [xlen-1:0]      rd_buf;
  logic [xlen-1:0]      res_buf;
  logic                 err_flag;
  logic                 start;
  logic [addr_size-1:0] addr;
  logic                 misalgn;
  logic [xlen-1:0]      lane_wdata;
  logic [strb_w-1:0]    lane_wmask;

  // Adder output doubles as the memory address
  assign addr = alu_res[addr_size-1:0];

  amo_sequencer u_seq (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .i_info        (i_info),
    .rs1           (rs1),
    .rs2           (rs2),
    .imm           (imm),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp       (icb_rsp),
    .o_ready       (o_ready),
    .alu_res       (alu_res),
    .state         (state),
    .alu_req       (alu_req),
    .rd_buf        (rd_buf),
    .res_buf       (res_buf),
    .err_flag      (err_flag)
  );

  agu_alu u_alu (
    .req (alu_req),
    .res (alu_res)
  );

  st_lane_align u_lane (
    .size       (i_info.size),
    .addr       (addr),
    .rs2        (rs2),
    .misalgn    (misalgn),
    .lane_wdata (lane_wdata),
    .lane_wmask (lane_wmask)
  );

  agu_issue u_issue (
    .i_valid       (i_valid),
    .i_info        (i_info),
    .o_ready       (o_ready),
    .icb_cmd_ready (icb_cmd_ready),
    .addr          (addr),
    .misalgn       (misalgn),
    .lane_wdata    (lane_wdata),
    .lane_wmask    (lane_wmask),
    .state         (state),
    .rd_buf        (rd_buf),
    .res_buf       (res_buf),
    .err_flag      (err_flag),
    .i_ready       (i_ready),
    .o_valid       (o_valid),
    .start         (start),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd       (icb_cmd),
    .wbck_wdat     (wbck_wdat),
    .wbck_err      (wbck_err),
    .cmt           (cmt),
    .amo_wait      (amo_wait)
  );

endmodule

`default_nettype wire

// File: sim/icb_mem_model.sv
// Behavioral memory on the command bus for the testbench; answers AMO traffic one cycle after the command
`default_nettype none

module icb_mem_model (
  input  wire               clk,
  input  wire               rst,
  input  wire               icb_cmd_valid,
  output logic              icb_cmd_ready,
  input  agu_pkg::icb_cmd_t icb_cmd,
  output logic              icb_rsp_valid,
  output agu_pkg::icb_rsp_t icb_rsp
);

  timeunit 1ns;
  timeprecision 100ps;

  import agu_pkg::*;

  // Byte addresses from here up map to no device
  localparam logic [addr_size-1:0] err_base = 32'h0000_0800;

  logic [xlen-1:0] mem [0:255];
  logic            take;
  logic            amo_open;
  logic            err;
  logic [7:0]      idx;
  icb_cmd_t        cmd_q;

  initial begin
    int i;
    int b;
    // Multiplicative hash of the word index
    for (i = 0; i < 256; i++) begin
      mem[i] = (i + 1) * 32'h9e37_79b9;
    end
    icb_cmd_ready = 1'b0;
    icb_rsp_valid = 1'b0;
    icb_rsp       = '0;
    amo_open      = 1'b0;
    forever begin
      // Handshake is stable mid-cycle
      @(negedge clk);
      take  = icb_cmd_valid & icb_cmd_ready & ~rst;
      cmd_q = icb_cmd;
      @(posedge clk);
      #1;
      icb_rsp_valid = 1'b0;
      if (take) begin
        err = (cmd_q.addr >= err_base);
        idx = cmd_q.addr[9:2];
        // Masked write, nothing lands in the error region
        if (!cmd_q.read && !err) begin
          for (b = 0; b < strb_w; b++) begin
            if (cmd_q.wmask[b]) begin
              mem[idx][8*b +: 8] = cmd_q.wdata[8*b +: 8];
            end
          end
        end
        // Locked read opens an AMO, the next command is its write
        if (cmd_q.lock || amo_open) begin
          icb_rsp_valid = 1'b1;
          icb_rsp.err   = err;
          icb_rsp.rdata = (cmd_q.read && !err) ? mem[idx] : '0;
          amo_open      = cmd_q.lock;
        end
      end
      icb_cmd_ready = ($urandom_range(0, 1) == 1);
    end
  end

endmodule

`default_nettype wire

// File: sim/agu_tb.sv
// Testbench for agu_top against a random-ready memory model; run with the Makefile sim target
`default_nettype none

module agu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import agu_pkg::*;

  //////////////////////////////////////////////////
  // Run length

  localparam int amo_rounds = 2;
  // Stores, loads, misaligned ld/st, AMOs, error AMO, misaligned AMO
  localparam int n_items    = 3 + 3 + 4 + 9 * amo_rounds + 2;
  localparam int max_cycles = 40 * n_items;

  // Expected response of one instruction
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wmask;
    logic            misalgn;
    logic            buserr;
    logic [xlen-1:0] old;
    logic [xlen-1:0] amo_res;
  } exp_t;

  logic            clk;
  logic            rst;
  logic            i_valid;
  logic            i_ready;
  agu_info_t       i_info;
  logic [xlen-1:0] rs1;
  logic [xlen-1:0] rs2;
  logic [xlen-1:0] imm;
  logic            o_valid;
  logic            o_ready;
  logic [xlen-1:0] wbck_wdat;
  logic            wbck_err;
  cmt_t            cmt;
  logic            amo_wait;
  logic            icb_cmd_valid;
  logic            icb_cmd_ready;
  icb_cmd_t        icb_cmd;
  logic            icb_rsp_valid;
  icb_rsp_t        icb_rsp;

  // Shared between stimulus and checker
  exp_t            cur;
  agu_info_t       cur_info;
  logic            active = 1'b0;
  logic            saw_wait = 1'b0;
  int              errors = 0;
  int              commits = 0;
  int              cmds = 0;
  int              item_cmds = 0;
  int              cycles = 0;

  agu_top dut0 (
    .clk           (clk),
    .rst           (rst),
    .i_valid       (i_valid),
    .i_ready       (i_ready),
    .i_info        (i_info),
    .rs1           (rs1),
    .rs2           (rs2),
    .imm           (imm),
    .o_valid       (o_valid),
    .o_ready       (o_ready),
    .wbck_wdat     (wbck_wdat),
    .wbck_err      (wbck_err),
    .cmt           (cmt),
    .amo_wait      (amo_wait),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp       (icb_rsp)
  );

  icb_mem_model mem0 (
    .clk           (clk),
    .rst           (rst),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp       (icb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Commit back-pressure with ready about three cycles in four
  initial begin
    o_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      o_ready = ($urandom_range(0, 3) != 0);
    end
  end

  //////////////////////////////////////////////////
  // Checks and reference

  task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("error %s got 0x%08h expected 0x%08h at %0t", name, got, want, $time);
    end
  endtask

  task automatic confirm(input bit ok, input string what);
    assert (ok) else begin
      errors++;
      $display("%s at %0t", what, $time);
    end
  endtask

  function automatic agu_info_t pack_info(input agu_op_e op, input acc_size_e size,
                                          input alu_op_e amo_op, input logic usign);
    agu_info_t info;
    info.op     = op;
    info.size   = size;
    info.amo_op = amo_op;
    info.usign  = usign;
    return info;
  endfunction

  // Expected bus and commit values from the ISA rules
  function automatic exp_t predict(input agu_info_t info, input logic [xlen-1:0] a,
                                   input logic [xlen-1:0] d, input logic [xlen-1:0] ofs,
                                   input logic [xlen-1:0] old);
    exp_t e;
    int   nb;
    int   lo;
    int   b;
    e      = '0;
    e.old  = old;
    // AMOs address with rs1 alone
    e.addr = (info.op == op_amo) ? a : a + ofs;
    case (info.size)
      size_b:  nb = 1;
      size_h:  nb = 2;
      default: nb = 4;
    endcase
    lo        = int'(e.addr[1:0]);
    e.misalgn = (lo % nb) != 0;
    // First lane of the naturally aligned group
    lo = lo - (lo % nb);
    for (b = 0; b < 4; b++) begin
      e.wdata[8*b +: 8] = d[8*(b % nb) +: 8];
      e.wmask[b]        = (b >= lo) && (b < lo + nb);
    end
    case (info.amo_op)
      alu_add:  e.amo_res = old + d;
      alu_swap: e.amo_res = d;
      alu_and:  e.amo_res = old & d;
      alu_or:   e.amo_res = old | d;
      alu_xor:  e.amo_res = old ^ d;
      alu_max:  e.amo_res = ($signed(old) > $signed(d)) ? old : d;
      alu_min:  e.amo_res = ($signed(old) < $signed(d)) ? old : d;
      alu_maxu: e.amo_res = (old > d) ? old : d;
      alu_minu: e.amo_res = (old < d) ? old : d;
      default:  e.amo_res = old;
    endcase
    e.buserr = (info.op == op_amo) && !e.misalgn && (e.addr >= 32'h800);
    return e;
  endfunction

  // Mid-cycle compare of every bus command and commit
  always @(negedge clk) begin
    if (!rst) begin
      if (amo_wait) begin
        saw_wait = 1'b1;
      end
      if (icb_cmd_valid && icb_cmd_ready) begin
        cmds++;
        item_cmds++;
        confirm(active, "bus command issued with no instruction pending");
        compare_word("icb_cmd.addr", icb_cmd.addr, cur.addr);
        if (cur_info.op == op_amo) begin
          // Locked read comes first and the write second
          compare_word("icb_cmd.read", 32'(icb_cmd.read), 32'(item_cmds == 1));
          compare_word("icb_cmd.lock", 32'(icb_cmd.lock), 32'(item_cmds == 1));
          if (item_cmds > 1) begin
            compare_word("icb_cmd.wmask", 32'(icb_cmd.wmask), cur.buserr ? 32'h0 : 32'hf);
            if (!cur.buserr) begin
              compare_word("icb_cmd.wdata", icb_cmd.wdata, cur.amo_res);
            end
          end
        end else begin
          confirm(o_valid && o_ready, "load or store command went out without its commit");
          compare_word("icb_cmd.read", 32'(icb_cmd.read), 32'(cur_info.op == op_load));
          compare_word("icb_cmd.lock", 32'(icb_cmd.lock), 32'h0);
          if (cur_info.op == op_store) begin
            compare_word("icb_cmd.wdata", icb_cmd.wdata, cur.wdata);
            compare_word("icb_cmd.wmask", 32'(icb_cmd.wmask), 32'(cur.wmask));
          end else begin
            compare_word("icb_cmd.size", 32'(icb_cmd.size), 32'(cur_info.size));
            compare_word("icb_cmd.usign", 32'(icb_cmd.usign), 32'(cur_info.usign));
          end
        end
      end
      if (o_valid && o_ready) begin
        commits++;
        confirm(i_valid && i_ready, "commit without the instruction being accepted");
        compare_word("cmt.misalgn", 32'(cmt.misalgn), 32'(cur.misalgn));
        compare_word("cmt.ld", 32'(cmt.ld), 32'(cur_info.op == op_load));
        compare_word("cmt.stamo", 32'(cmt.stamo), 32'(cur_info.op != op_load));
        compare_word("cmt.buserr", 32'(cmt.buserr), 32'(cur.buserr));
        compare_word("cmt.badaddr", cmt.badaddr, cur.addr);
        compare_word("wbck_err", 32'(wbck_err), 32'(cur.misalgn | cur.buserr));
        if (cur_info.op == op_amo && !cur.misalgn) begin
          if (!cur.buserr) begin
            compare_word("wbck_wdat", wbck_wdat, cur.old);
          end
        end else begin
          compare_word("wbck_wdat", wbck_wdat, 32'h0);
        end
      end
    end
  end

  // Run limit
  initial begin
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with the run unfinished", max_cycles);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus

  // Hold one instruction until accepted, then check its aftermath
  task automatic issue_item(input agu_info_t info, input logic [xlen-1:0] a,
                            input logic [xlen-1:0] d, input logic [xlen-1:0] ofs);
    int              idx;
    int              seen_cmt;
    int              want_cmd;
    logic [xlen-1:0] old;
    idx       = int'(a[9:2]);
    old       = mem0.mem[idx];
    cur       = predict(info, a, d, ofs, old);
    cur_info  = info;
    seen_cmt  = commits;
    item_cmds = 0;
    if (cur.misalgn) begin
      want_cmd = 0;
    end else if (info.op == op_amo) begin
      want_cmd = 2;
    end else begin
      want_cmd = 1;
    end
    saw_wait = 1'b0;
    active   = 1'b1;
    i_info   = info;
    rs1      = a;
    rs2      = d;
    imm      = ofs;
    i_valid  = 1'b1;
    do begin
      @(negedge clk);
    end while (!i_ready);
    @(posedge clk);
    #1;
    i_valid = 1'b0;
    active  = 1'b0;
    confirm(commits == seen_cmt + 1, "instruction did not commit exactly once");
    confirm(item_cmds == want_cmd, "wrong number of bus commands for the instruction");
    if (info.op == op_amo && !cur.misalgn) begin
      confirm(saw_wait, "amo_wait stayed low during the AMO");
      confirm(!amo_wait, "amo_wait still high after the AMO retired");
      if (cur.buserr) begin
        compare_word("mem (error region)", mem0.mem[idx], old);
      end else begin
        compare_word("mem", mem0.mem[idx], cur.amo_res);
      end
    end else begin
      confirm(!saw_wait, "amo_wait rose for a plain or misaligned access");
    end
    // Idle cycle between instructions
    @(posedge clk);
    #1;
  endtask

  initial begin
    int              r;
    int              k;
    logic [xlen-1:0] a;
    logic [xlen-1:0] d;
    logic [xlen-1:0] ofs;
    void'($urandom(4));
    rst     = 1'b1;
    i_valid = 1'b0;
    i_info  = '0;
    rs1     = '0;
    rs2     = '0;
    imm     = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;

    // Aligned stores to byte lane 3, the upper half and the full word
    issue_item(pack_info(op_store, size_b, alu_add, 1'b0), 32'h100, 32'h1234_56a7, 32'h3);
    issue_item(pack_info(op_store, size_h, alu_add, 1'b0), 32'h100, 32'h89ab_cdef, 32'h6);
    issue_item(pack_info(op_store, size_w, alu_add, 1'b0), 32'h100, 32'h0bad_f00d, 32'h8);
    // Aligned loads
    issue_item(pack_info(op_load, size_b, alu_add, 1'b1), 32'h200, 32'h0, 32'h1);
    issue_item(pack_info(op_load, size_h, alu_add, 1'b0), 32'h200, 32'h0, 32'h2);
    issue_item(pack_info(op_load, size_w, alu_add, 1'b1), 32'h200, 32'h0, 32'h4);
    // Misaligned loads and stores
    issue_item(pack_info(op_load, size_h, alu_add, 1'b0), 32'h300, 32'h0, 32'h1);
    issue_item(pack_info(op_load, size_w, alu_add, 1'b0), 32'h300, 32'h0, 32'h2);
    issue_item(pack_info(op_store, size_h, alu_add, 1'b0), 32'h300, 32'h5555_aaaa, 32'h3);
    issue_item(pack_info(op_store, size_w, alu_add, 1'b0), 32'h300, 32'h5555_aaaa, 32'h5);

    // Every AMO opcode on random words with an imm that must not move the address
    for (r = 0; r < amo_rounds; r++) begin
      for (k = 0; k < 9; k++) begin
        a   = $urandom() & 32'h0000_03fc;
        d   = $urandom();
        ofs = $urandom_range(1, 255);
        issue_item(pack_info(op_amo, size_w, alu_op_e'(4'(k)), 1'b0), a, d, ofs);
      end
    end

    // Read fault makes the write go out with an empty mask
    issue_item(pack_info(op_amo, size_w, alu_or, 1'b0), 32'h840, $urandom(), 32'h10);
    // Misaligned AMO commits at once
    issue_item(pack_info(op_amo, size_w, alu_add, 1'b0), 32'h122, 32'h1, 32'h4);

    $display("errors %0d, commits %0d, bus commands %0d", errors, commits, cmds);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/agu_pkg.sv
hw/agu_alu.sv
hw/st_lane_align.sv
hw/amo_sequencer.sv
hw/agu_issue.sv
hw/agu_top.sv
sim/icb_mem_model.sv
sim/agu_tb.sv

// File: Makefile
# Verilator flow for the load/store address unit
OBJ := obj_dir
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sources.f --top-module agu_top
	verilator --lint-only --timing --timescale 1ns/1ps -f sources.f --top-module agu_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module agu_tb -Mdir $(OBJ) -o agu_sim
	./$(OBJ)/agu_sim | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
